// ==== hw/jf_defs.svh ====
// Shared constants for the cabinet glue logic.
// Include in any file that decodes keys, loads DIPs, drives the PLL
// reconfiguration port or maps colour levels.
`ifndef JF_DEFS_SVH
`define JF_DEFS_SVH

// ============================================================
// PS/2 set 2 make codes
// ============================================================
`define JF_KEY_1       8'h16
`define JF_KEY_2       8'h1E
`define JF_KEY_5       8'h2E
`define JF_KEY_6       8'h36
`define JF_KEY_9       8'h46
`define JF_KEY_P       8'h4D
`define JF_KEY_UP      8'h75
`define JF_KEY_DOWN    8'h72
`define JF_KEY_LEFT    8'h6B
`define JF_KEY_RIGHT   8'h74
`define JF_KEY_CTRL    8'h14

// Bit positions in the held key vector
`define JF_KB_RIGHT    0
`define JF_KB_LEFT     1
`define JF_KB_DOWN     2
`define JF_KB_UP       3
`define JF_KB_FIRE     4
`define JF_KB_COIN1    5
`define JF_KB_COIN2    6
`define JF_KB_START1   7
`define JF_KB_START2   8
`define JF_KB_SERVICE  9
`define JF_KB_PAUSE    10

// Download index carrying the DIP bytes
`define JF_DIP_INDEX   8'd254

// ============================================================
// PLL reconfiguration registers and words
// ============================================================
`define JF_PLL_ADDR_MODE   6'd0
`define JF_PLL_ADDR_M      6'd7
`define JF_PLL_ADDR_START  6'd2
`define JF_PLL_K_UNDER     32'd3268298314
`define JF_PLL_K_NATIVE    32'd3639383488

// Per-bit weights, they add up to 0xFF for a full level
`define JF_LVL_W0      8'h19
`define JF_LVL_W1      8'h24
`define JF_LVL_W2      8'h35
`define JF_LVL_W3      8'h40
`define JF_LVL_W4      8'h4D

// Aspect words when the menu asks for the original ratio
`define JF_AR_LONG     13'd16
`define JF_AR_SHORT    13'd14

`endif

// ==== hw/jf_pkg.sv ====
// Types shared by the cabinet glue modules and the testbench.
// Refer to them with jf_pkg:: scoped names.
`default_nettype none

package jf_pkg;

	// ============================================================
	// Plain vectors
	// ============================================================
	// Gamepad word, bit 0 right .. 3 up, 4 fire L, 5 fire R,
	// 6 flash bomb, 7 coin, 8 start 1, 9 start 2
	typedef logic [15:0] joy_t;
	// Active-low DIP bytes, byte 1 in the upper half
	typedef logic [15:0] dip_word_t;
	typedef logic [4:0]  level5_t;
	typedef logic [7:0]  level8_t;
	typedef logic [12:0] aspect_t;
	typedef logic [5:0]  pll_addr_t;
	typedef logic [31:0] pll_data_t;

	// Reconfiguration sequencer steps
	typedef enum logic [2:0] {
		IDLE, S1, S2, S3, S4, S5, S6, S7
	} cfg_state_t;

	// ============================================================
	// Bundles
	// ============================================================
	// PS/2 event, a new one flips toggle
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [7:0] code;
	} ps2_event_t;

	// Download port write, one strobe per byte
	typedef struct packed {
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} ioctl_wr_t;

	typedef struct packed {
		logic [1:0] aspect;
		logic       horizontal;
		logic       underclock;
	} osd_settings_t;

	// Everything here is active low
	typedef struct packed {
		logic [1:0] coin;
		logic [1:0] start;
		logic [3:0] p1_joy;
		logic [3:0] p2_joy;
		logic       p1_fire;
		logic       p2_fire;
		logic       fire1_r;
		logic       flash1;
		logic       fire2_r;
		logic       flash2;
		logic       service;
	} cabinet_t;

	typedef struct packed {
		level5_t r;
		level5_t g;
		level5_t b;
		logic    hblank;
		logic    vblank;
	} game_rgb_t;

	typedef struct packed {
		level8_t r;
		level8_t g;
		level8_t b;
		logic    de;
	} vga_t;

	// Write side of the PLL management port
	typedef struct packed {
		logic      write;
		pll_addr_t address;
		pll_data_t data;
	} pll_cfg_t;

endpackage

`default_nettype wire

// ==== hw/jf_key_decoder.sv ====
// PS/2 keyboard decoder. Turns key events into a vector of held buttons.
// A new event is flagged by a change of the toggle bit, not by a strobe.
`default_nettype none
`include "jf_defs.svh"

module jf_key_decoder (
	input  wire                 CLK_49M,
	input  wire                 rst,
	input  jf_pkg::ps2_event_t  ps2_key,
	output logic [10:0]         keys
);

	// Input register, the event is looked at one edge after capture
	jf_pkg::ps2_event_t ps2_q;
	logic               toggle_q;
	logic               new_event;

	always_ff @(posedge CLK_49M) begin
		ps2_q <= ps2_key;
	end

	// Toggle moved since the last look
	assign new_event = ps2_q.toggle != toggle_q;

	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			// Follow the live toggle so no event fires out of reset
			toggle_q <= ps2_key.toggle;
			keys     <= '0;
		end else begin
			toggle_q <= ps2_q.toggle;
			if (new_event) begin
				// Make or break sets the held state, unknown codes dropped
				case (ps2_q.code)
					`JF_KEY_1:     keys[`JF_KB_START1]  <= ps2_q.pressed;
					`JF_KEY_2:     keys[`JF_KB_START2]  <= ps2_q.pressed;
					`JF_KEY_5:     keys[`JF_KB_COIN1]   <= ps2_q.pressed;
					`JF_KEY_6:     keys[`JF_KB_COIN2]   <= ps2_q.pressed;
					`JF_KEY_9:     keys[`JF_KB_SERVICE] <= ps2_q.pressed;
					`JF_KEY_P:     keys[`JF_KB_PAUSE]   <= ps2_q.pressed;
					`JF_KEY_UP:    keys[`JF_KB_UP]      <= ps2_q.pressed;
					`JF_KEY_DOWN:  keys[`JF_KB_DOWN]    <= ps2_q.pressed;
					`JF_KEY_LEFT:  keys[`JF_KB_LEFT]    <= ps2_q.pressed;
					`JF_KEY_RIGHT: keys[`JF_KB_RIGHT]   <= ps2_q.pressed;
					`JF_KEY_CTRL:  keys[`JF_KB_FIRE]    <= ps2_q.pressed;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/jf_cabinet_inputs.sv ====
// Cabinet input merge. Keyboard buttons are ORed with the gamepads and
// inverted to the active-low levels the game expects.
// Also captures the two DIP bytes from the download port.
`default_nettype none
`include "jf_defs.svh"

module jf_cabinet_inputs (
	input  wire                 CLK_49M,
	input  wire                 rst,
	input  wire  [10:0]         keys,
	input  jf_pkg::joy_t        joystick_0,
	input  jf_pkg::joy_t        joystick_1,
	input  jf_pkg::ioctl_wr_t   ioctl,
	output jf_pkg::cabinet_t    cabinet,
	output jf_pkg::dip_word_t   dip_sw
);

	logic [1:0][7:0] dip_q;
	logic            dip_hit;

	// ============================================================
	// Button merge
	// ============================================================
	always_comb begin
		// Coin 2 is keyboard only
		cabinet.coin    = ~{keys[`JF_KB_COIN2], keys[`JF_KB_COIN1] | joystick_0[7]};
		cabinet.start   = ~{keys[`JF_KB_START2] | joystick_0[9],
			keys[`JF_KB_START1] | joystick_0[8]};
		// Order is right, left, down, up as in the gamepad word
		cabinet.p1_joy  = ~{keys[`JF_KB_RIGHT] | joystick_0[0],
			keys[`JF_KB_LEFT] | joystick_0[1],
			keys[`JF_KB_DOWN] | joystick_0[2],
			keys[`JF_KB_UP] | joystick_0[3]};
		// Player 2 has no keyboard share
		cabinet.p2_joy  = ~{joystick_1[0], joystick_1[1], joystick_1[2], joystick_1[3]};
		// Ctrl is fire left
		cabinet.p1_fire = ~(keys[`JF_KB_FIRE] | joystick_0[4]);
		cabinet.p2_fire = ~joystick_1[4];
		cabinet.fire1_r = ~joystick_0[5];
		cabinet.flash1  = ~joystick_0[6];
		cabinet.fire2_r = ~joystick_1[5];
		cabinet.flash2  = ~joystick_1[6];
		cabinet.service = ~keys[`JF_KB_SERVICE];
	end

	// ============================================================
	// DIP bytes
	// ============================================================
	// Only bytes 0 and 1 matter to the game
	assign dip_hit = ioctl.wr && (ioctl.index == `JF_DIP_INDEX) && (ioctl.addr[24:1] == '0);

	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			dip_q <= '0;
		end else if (dip_hit) begin
			dip_q[ioctl.addr[0]] <= ioctl.data;
		end
	end

	// Stored inverted so a cleared byte reads as all switches off
	assign dip_sw = ~dip_q;

endmodule

`default_nettype wire

// ==== hw/jf_pll_reconfig.sv ====
// PLL underclock sequencer. Watches the underclock request and, on a
// settled change, writes mode, M/K value and start to the PLL management
// port. The port's waitrequest freezes the sequence.
`default_nettype none
`include "jf_defs.svh"

module jf_pll_reconfig (
	input  wire                CLK_49M,
	input  wire                rst,
	input  wire                underclock,
	input  wire                cfg_waitrequest,
	output jf_pkg::pll_cfg_t   cfg
);

	jf_pkg::cfg_state_t step;
	logic               req_s1;
	logic               req_s2;
	logic               applied;
	logic               start_seq;
	logic               cfg_write;
	jf_pkg::pll_addr_t  cfg_addr;
	jf_pkg::pll_data_t  cfg_data;

	// Two samples agree and differ from what the PLL runs at
	assign start_seq = (req_s1 == req_s2) && (req_s2 != applied);

	// ============================================================
	// Control
	// ============================================================
	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			req_s1    <= 1'b0;
			req_s2    <= 1'b0;
			applied   <= 1'b0;
			step      <= jf_pkg::IDLE;
			cfg_write <= 1'b0;
		end else begin
			req_s1    <= underclock;
			req_s2    <= req_s1;
			cfg_write <= 1'b0;
			if (!cfg_waitrequest) begin
				// S7 wraps back to IDLE
				if (step != jf_pkg::IDLE)
					step <= jf_pkg::cfg_state_t'(step + 3'd1);
				if (step == jf_pkg::S1 || step == jf_pkg::S5 || step == jf_pkg::S7)
					cfg_write <= 1'b1;
			end
			// New request wins over the advance, sequence starts again
			if (start_seq) begin
				step    <= jf_pkg::S1;
				applied <= req_s2;
			end
		end
	end

	// ============================================================
	// Write payload
	// ============================================================
	always_ff @(posedge CLK_49M) begin
		if (!cfg_waitrequest) begin
			case (step)
				jf_pkg::S1: begin
					cfg_addr <= `JF_PLL_ADDR_MODE;
					cfg_data <= '0;
				end
				jf_pkg::S5: begin
					// Slightly slower clock brings vsync to 60 Hz
					cfg_addr <= `JF_PLL_ADDR_M;
					cfg_data <= applied ? `JF_PLL_K_UNDER : `JF_PLL_K_NATIVE;
				end
				jf_pkg::S7: begin
					cfg_addr <= `JF_PLL_ADDR_START;
					cfg_data <= '0;
				end
				default: ;
			endcase
		end
	end

	assign cfg = '{write: cfg_write, address: cfg_addr, data: cfg_data};

endmodule

`default_nettype wire

// ==== hw/jf_video_out.sv ====
// Video output stage. Maps the game's 5-bit levels onto 8-bit levels that
// match the PCB resistor network, registers them with display enable,
// and picks the scaler aspect words.
`default_nettype none
`include "jf_defs.svh"

module jf_video_out (
	input  wire                    CLK_49M,
	input  wire                    rst,
	input  jf_pkg::game_rgb_t      game_rgb,
	input  jf_pkg::osd_settings_t  osd,
	output jf_pkg::vga_t           vga,
	output jf_pkg::aspect_t        video_arx,
	output jf_pkg::aspect_t        video_ary
);

	// Sum of the weights of the set bits
	function automatic jf_pkg::level8_t weigh(input jf_pkg::level5_t lvl);
		jf_pkg::level8_t sum;
		sum = '0;
		if (lvl[0]) sum = sum + `JF_LVL_W0;
		if (lvl[1]) sum = sum + `JF_LVL_W1;
		if (lvl[2]) sum = sum + `JF_LVL_W2;
		if (lvl[3]) sum = sum + `JF_LVL_W3;
		if (lvl[4]) sum = sum + `JF_LVL_W4;
		return sum;
	endfunction

	// ============================================================
	// Colour
	// ============================================================
	always_ff @(posedge CLK_49M) begin
		vga.r <= weigh(game_rgb.r);
		vga.g <= weigh(game_rgb.g);
		vga.b <= weigh(game_rgb.b);
	end

	// Enable follows the colour by the same one cycle
	always_ff @(posedge CLK_49M) begin
		if (rst)
			vga.de <= 1'b0;
		else
			vga.de <= ~(game_rgb.hblank | game_rgb.vblank);
	end

	// Aspect 0 is the original ratio, others are scaler presets
	always_comb begin
		if (osd.aspect == 2'd0) begin
			video_arx = osd.horizontal ? `JF_AR_LONG : `JF_AR_SHORT;
			video_ary = osd.horizontal ? `JF_AR_SHORT : `JF_AR_LONG;
		end else begin
			video_arx = jf_pkg::aspect_t'(osd.aspect) - 13'd1;
			video_ary = '0;
		end
	end

endmodule

`default_nettype wire

// ==== hw/jf_top.sv ====
// Top of the cabinet glue. Keyboard and gamepads in, cabinet inputs and
// DIPs out; underclock request to PLL writes; game colour to VGA.
`default_nettype none

module jf_top (
	input  wire                    CLK_49M,
	input  wire                    rst,
	input  jf_pkg::ps2_event_t     ps2_key,
	input  jf_pkg::joy_t           joystick_0,
	input  jf_pkg::joy_t           joystick_1,
	input  jf_pkg::ioctl_wr_t      ioctl,
	input  jf_pkg::osd_settings_t  osd,
	input  jf_pkg::game_rgb_t      game_rgb,
	input  wire                    cfg_waitrequest,
	output jf_pkg::cabinet_t       cabinet,
	output jf_pkg::dip_word_t      dip_sw,
	output jf_pkg::pll_cfg_t       cfg,
	output jf_pkg::vga_t           vga,
	output jf_pkg::aspect_t        video_arx,
	output jf_pkg::aspect_t        video_ary
);

	// Held keyboard buttons, active high
	logic [10:0] keys;

	// ============================================================
	// Input side
	// ============================================================
	jf_key_decoder i_key_decoder (
		.CLK_49M (CLK_49M),
		.rst     (rst),
		.ps2_key (ps2_key),
		.keys    (keys)
	);

	jf_cabinet_inputs i_cabinet_inputs (
		.CLK_49M    (CLK_49M),
		.rst        (rst),
		.keys       (keys),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.ioctl      (ioctl),
		.cabinet    (cabinet),
		.dip_sw     (dip_sw)
	);

	// PLL management writes, frozen by waitrequest
	jf_pll_reconfig i_pll_reconfig (
		.CLK_49M         (CLK_49M),
		.rst             (rst),
		.underclock      (osd.underclock),
		.cfg_waitrequest (cfg_waitrequest),
		.cfg             (cfg)
	);

	// ============================================================
	// Output side
	// ============================================================
	jf_video_out i_video_out (
		.CLK_49M   (CLK_49M),
		.rst       (rst),
		.game_rgb  (game_rgb),
		.osd       (osd),
		.vga       (vga),
		.video_arx (video_arx),
		.video_ary (video_ary)
	);

endmodule

`default_nettype wire

// ==== verif/jf_chk.sv ====
// Concurrent assertions on the glue outputs.
// Attached to jf_top with bind from the testbench.
`default_nettype none
`include "jf_defs.svh"

module jf_chk (
	input  wire                CLK_49M,
	input  wire                rst,
	input  jf_pkg::pll_cfg_t   cfg,
	input  jf_pkg::game_rgb_t  game_rgb,
	input  jf_pkg::vga_t       vga
);

	// Count of failed assertions, read by the testbench
	int failures = 0;

	// ============================================================
	// PLL management port
	// ============================================================
	// Write is a single-cycle strobe
	a_write_strobe: assert property (@(posedge CLK_49M) disable iff (rst)
		cfg.write |=> !cfg.write)
	else begin
		$error("PLL write held high for two cycles");
		failures++;
	end

	// Only the mode, M/K and start registers are touched
	a_write_addr: assert property (@(posedge CLK_49M) disable iff (rst)
		cfg.write |-> (cfg.address == `JF_PLL_ADDR_MODE || cfg.address == `JF_PLL_ADDR_M ||
			cfg.address == `JF_PLL_ADDR_START))
	else begin
		$error("PLL write to an unexpected address");
		failures++;
	end

	// ============================================================
	// Video
	// ============================================================
	a_blank_de: assert property (@(posedge CLK_49M) disable iff (rst)
		(game_rgb.hblank || game_rgb.vblank) |=> !vga.de)
	else begin
		$error("Display enable high after a blanked pixel");
		failures++;
	end

endmodule

`default_nettype wire

// ==== verif/jf_tb.sv ====
// Testbench for the cabinet glue top level.
// Drives keyboard, gamepads, download port, colour and menu inputs from a fixed seed.
// A model advanced on every clock predicts the outputs, and they are compared each cycle.
`default_nettype none
`include "jf_defs.svh"

module jf_tb;

	// Test lengths in stimulus events
	localparam int KEY_EVENTS  = 160;
	localparam int PAD_STEPS   = 200;
	localparam int DIP_WRITES  = 48;
	localparam int RGB_STEPS   = 200;
	localparam int PLL_TOGGLES = 4;
	// Cycles allowed per underclock change, stalls and settling included
	localparam int PLL_SLOT    = 128;
	// Reset 4, key event 3 cycles, DIP write 2, aspect 8 combinations
	localparam int TEST_CYCLES = 4 + KEY_EVENTS * 3 + PAD_STEPS + DIP_WRITES * 2 +
		RGB_STEPS + 8 + PLL_TOGGLES * PLL_SLOT;
	// Twice the nominal length
	localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

	logic                   CLK_49M;
	logic                   rst;
	jf_pkg::ps2_event_t     ps2_key;
	jf_pkg::joy_t           joystick_0;
	jf_pkg::joy_t           joystick_1;
	jf_pkg::ioctl_wr_t      ioctl;
	jf_pkg::osd_settings_t  osd;
	jf_pkg::game_rgb_t      game_rgb;
	logic                   cfg_waitrequest;
	jf_pkg::cabinet_t       cabinet;
	jf_pkg::dip_word_t      dip_sw;
	jf_pkg::pll_cfg_t       cfg;
	jf_pkg::vga_t           vga;
	jf_pkg::aspect_t        video_arx;
	jf_pkg::aspect_t        video_ary;

	// Model state, as it stands after the last rising edge
	logic [10:0]            held_keys;
	logic                   last_toggle;
	logic                   key_pending;
	jf_pkg::ps2_event_t     pending_ev;
	logic [1:0][7:0]        dip_bytes;
	jf_pkg::vga_t           vga_exp;
	// PLL writes still to come, oldest first
	jf_pkg::pll_cfg_t       exp_cfg[$];
	integer                 seed;
	int                     cycle_count = 0;

	jf_top i_jf_top (
		.CLK_49M         (CLK_49M),
		.rst             (rst),
		.ps2_key         (ps2_key),
		.joystick_0      (joystick_0),
		.joystick_1      (joystick_1),
		.ioctl           (ioctl),
		.osd             (osd),
		.game_rgb        (game_rgb),
		.cfg_waitrequest (cfg_waitrequest),
		.cabinet         (cabinet),
		.dip_sw          (dip_sw),
		.cfg             (cfg),
		.vga             (vga),
		.video_arx       (video_arx),
		.video_ary       (video_ary)
	);

	bind jf_top jf_chk i_chk (
		.CLK_49M  (CLK_49M),
		.rst      (rst),
		.cfg      (cfg),
		.game_rgb (game_rgb),
		.vga      (vga)
	);

	initial begin
		CLK_49M = 1'b0;
		forever #5 CLK_49M = ~CLK_49M;
	end

	// ============================================================
	// Reference functions
	// ============================================================
	// Held key slot for a code, -1 when the code is not mapped
	function automatic int key_slot(input logic [7:0] code);
		case (code)
			`JF_KEY_1:     return `JF_KB_START1;
			`JF_KEY_2:     return `JF_KB_START2;
			`JF_KEY_5:     return `JF_KB_COIN1;
			`JF_KEY_6:     return `JF_KB_COIN2;
			`JF_KEY_9:     return `JF_KB_SERVICE;
			`JF_KEY_P:     return `JF_KB_PAUSE;
			`JF_KEY_UP:    return `JF_KB_UP;
			`JF_KEY_DOWN:  return `JF_KB_DOWN;
			`JF_KEY_LEFT:  return `JF_KB_LEFT;
			`JF_KEY_RIGHT: return `JF_KB_RIGHT;
			`JF_KEY_CTRL:  return `JF_KB_FIRE;
			default:       return -1;
		endcase
	endfunction

	// Keyboard OR gamepad per joy_t bit, then inverted
	function automatic jf_pkg::cabinet_t merged_cabinet(input logic [10:0] k,
		input jf_pkg::joy_t j0, input jf_pkg::joy_t j1);
		jf_pkg::cabinet_t c;
		c.coin    = ~{k[`JF_KB_COIN2], k[`JF_KB_COIN1] | j0[7]};
		c.start   = ~{k[`JF_KB_START2] | j0[9], k[`JF_KB_START1] | j0[8]};
		// Right in the top bit, up in the bottom
		c.p1_joy  = ~{k[`JF_KB_RIGHT] | j0[0], k[`JF_KB_LEFT] | j0[1],
			k[`JF_KB_DOWN] | j0[2], k[`JF_KB_UP] | j0[3]};
		c.p2_joy  = ~{j1[0], j1[1], j1[2], j1[3]};
		c.p1_fire = ~(k[`JF_KB_FIRE] | j0[4]);
		c.p2_fire = ~j1[4];
		c.fire1_r = ~j0[5];
		c.flash1  = ~j0[6];
		c.fire2_r = ~j1[5];
		c.flash2  = ~j1[6];
		c.service = ~k[`JF_KB_SERVICE];
		return c;
	endfunction

	function automatic jf_pkg::dip_word_t inverted_dips(input logic [1:0][7:0] bytes);
		return ~{bytes[1], bytes[0]};
	endfunction

	// Resistor network weights of the set bits
	function automatic jf_pkg::level8_t weigh_level(input jf_pkg::level5_t lvl);
		return (lvl[0] ? `JF_LVL_W0 : 8'h00) + (lvl[1] ? `JF_LVL_W1 : 8'h00) +
			(lvl[2] ? `JF_LVL_W2 : 8'h00) + (lvl[3] ? `JF_LVL_W3 : 8'h00) +
			(lvl[4] ? `JF_LVL_W4 : 8'h00);
	endfunction

	function automatic jf_pkg::vga_t mapped_vga(input jf_pkg::game_rgb_t g);
		jf_pkg::vga_t v;
		v.r  = weigh_level(g.r);
		v.g  = weigh_level(g.g);
		v.b  = weigh_level(g.b);
		v.de = ~(g.hblank | g.vblank);
		return v;
	endfunction

	function automatic jf_pkg::aspect_t expected_arx(input jf_pkg::osd_settings_t o);
		if (o.aspect == 2'd0)
			return o.horizontal ? `JF_AR_LONG : `JF_AR_SHORT;
		return {11'd0, o.aspect} - 13'd1;
	endfunction

	function automatic jf_pkg::aspect_t expected_ary(input jf_pkg::osd_settings_t o);
		if (o.aspect == 2'd0)
			return o.horizontal ? `JF_AR_SHORT : `JF_AR_LONG;
		return 13'd0;
	endfunction

	// Write number idx of one reconfiguration, mode then M/K then start
	function automatic jf_pkg::pll_cfg_t pll_step_write(input int idx, input logic under);
		jf_pkg::pll_cfg_t w;
		w.write   = 1'b1;
		w.address = `JF_PLL_ADDR_MODE;
		w.data    = 32'd0;
		if (idx == 1) begin
			w.address = `JF_PLL_ADDR_M;
			w.data    = under ? `JF_PLL_K_UNDER : `JF_PLL_K_NATIVE;
		end else if (idx == 2) begin
			w.address = `JF_PLL_ADDR_START;
		end
		return w;
	endfunction

	// ============================================================
	// Failure handling and compare tasks
	// ============================================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_cabinet(input jf_pkg::cabinet_t got, input jf_pkg::cabinet_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR t=%0t cabinet got %h expected %h", $time, got, exp));
	endtask

	task automatic check_dip(input jf_pkg::dip_word_t got, input jf_pkg::dip_word_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR t=%0t dip_sw got %h expected %h", $time, got, exp));
	endtask

	task automatic check_vga(input jf_pkg::vga_t got, input jf_pkg::vga_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR t=%0t vga got %h expected %h", $time, got, exp));
	endtask

	task automatic check_aspect(input jf_pkg::aspect_t got_x, input jf_pkg::aspect_t got_y,
		input jf_pkg::aspect_t exp_x, input jf_pkg::aspect_t exp_y);
		if (got_x !== exp_x || got_y !== exp_y)
			abort_run($sformatf("ERR t=%0t aspect got %0d:%0d expected %0d:%0d",
				$time, got_x, got_y, exp_x, exp_y));
	endtask

	task automatic check_cfg(input jf_pkg::pll_cfg_t got, input jf_pkg::pll_cfg_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR t=%0t PLL write addr %0d data %h expected addr %0d data %h",
				$time, got.address, got.data, exp.address, exp.data));
	endtask

	// ============================================================
	// Comparison process
	// ============================================================
	// Outputs are settled at the falling edge, inputs too
	always @(negedge CLK_49M) begin : compare
		jf_pkg::pll_cfg_t next_w;
		int               slot;
		if (!rst) begin
			check_cabinet(cabinet, merged_cabinet(held_keys, joystick_0, joystick_1));
			check_dip(dip_sw, inverted_dips(dip_bytes));
			check_vga(vga, vga_exp);
			check_aspect(video_arx, video_ary, expected_arx(osd), expected_ary(osd));
			if (cfg.write) begin
				if (exp_cfg.size() == 0)
					abort_run($sformatf("ERR t=%0t PLL write with none expected", $time));
				next_w = exp_cfg.pop_front();
				check_cfg(cfg, next_w);
			end
			if (i_jf_top.i_chk.failures != 0)
				abort_run("An assertion in the bound checker failed");
		end
		// Step the model over the next rising edge
		if (rst) begin
			held_keys   = '0;
			key_pending = 1'b0;
			last_toggle = ps2_key.toggle;
			dip_bytes   = '0;
			vga_exp     = mapped_vga(game_rgb);
			vga_exp.de  = 1'b0;
		end else begin
			// Event sampled one edge ago reaches the held keys now
			if (key_pending) begin
				slot = key_slot(pending_ev.code);
				if (slot >= 0)
					held_keys[slot[3:0]] = pending_ev.pressed;
			end
			key_pending = ps2_key.toggle != last_toggle;
			pending_ev  = ps2_key;
			last_toggle = ps2_key.toggle;
			if (ioctl.wr && ioctl.index == `JF_DIP_INDEX && ioctl.addr < 25'd2)
				dip_bytes[ioctl.addr[0]] = ioctl.data;
			vga_exp = mapped_vga(game_rgb);
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================
	// One PS/2 event, fresh ones flip toggle
	task automatic send_key(input logic [7:0] code, input logic pressed, input logic fresh);
		jf_pkg::ps2_event_t ev;
		ev.toggle  = fresh ? ~ps2_key.toggle : ps2_key.toggle;
		ev.pressed = pressed;
		ev.code    = code;
		ps2_key <= ev;
	endtask

	// Mostly mapped codes, otherwise any byte
	function automatic logic [7:0] pick_code(input logic [3:0] sel, input logic [7:0] other);
		case (sel)
			4'd0:    return `JF_KEY_1;
			4'd1:    return `JF_KEY_2;
			4'd2:    return `JF_KEY_5;
			4'd3:    return `JF_KEY_6;
			4'd4:    return `JF_KEY_9;
			4'd5:    return `JF_KEY_P;
			4'd6:    return `JF_KEY_UP;
			4'd7:    return `JF_KEY_DOWN;
			4'd8:    return `JF_KEY_LEFT;
			4'd9:    return `JF_KEY_RIGHT;
			4'd10:   return `JF_KEY_CTRL;
			default: return other;
		endcase
	endfunction

	task automatic drive_key_events();
		logic [31:0] r;
		for (int n = 0; n < KEY_EVENTS; n++) begin
			@(posedge CLK_49M);
			r = $random(seed);
			// A quarter keep the old toggle and must do nothing
			send_key(pick_code(r[3:0], r[15:8]), r[16], r[18:17] != 2'b00);
			repeat (2) @(posedge CLK_49M);
		end
	endtask

	task automatic mix_gamepads();
		logic [31:0] r;
		logic [31:0] k;
		for (int n = 0; n < PAD_STEPS; n++) begin
			@(posedge CLK_49M);
			r = $random(seed);
			joystick_0 <= r[15:0];
			joystick_1 <= r[31:16];
			// Keep the held keys moving under the pads
			if (n % 8 == 0) begin
				k = $random(seed);
				send_key(pick_code(k[3:0], k[15:8]), k[16], 1'b1);
			end
		end
	endtask

	task automatic load_dips();
		logic [31:0]       r;
		jf_pkg::ioctl_wr_t w;
		for (int n = 0; n < DIP_WRITES; n++) begin
			@(posedge CLK_49M);
			r = $random(seed);
			w.wr    = 1'b1;
			w.index = (r[1:0] != 2'b00) ? `JF_DIP_INDEX : r[23:16];
			// Byte 0 to 3, high address bits now and then
			w.addr  = {r[14:12] & {3{r[6]}}, 20'd0, r[3:2]};
			w.data  = r[31:24];
			ioctl <= w;
			@(posedge CLK_49M);
			ioctl.wr <= 1'b0;
		end
	endtask

	task automatic sweep_colours();
		logic [31:0] r;
		for (int n = 0; n < RGB_STEPS; n++) begin
			@(posedge CLK_49M);
			r = $random(seed);
			game_rgb <= r[16:0];
		end
	endtask

	task automatic sweep_aspect();
		for (int a = 0; a < 4; a++) begin
			for (int h = 0; h < 2; h++) begin
				@(posedge CLK_49M);
				osd.aspect     <= a[1:0];
				osd.horizontal <= h[0];
			end
		end
	endtask

	// Each change of the request expects mode, M/K and start in order
	task automatic cycle_underclock();
		logic        under;
		logic [31:0] r;
		under = 1'b0;
		for (int t = 0; t < PLL_TOGGLES; t++) begin
			under = ~under;
			for (int i = 0; i < 3; i++)
				exp_cfg.push_back(pll_step_write(i, under));
			@(posedge CLK_49M);
			osd.underclock <= under;
			while (exp_cfg.size() != 0) begin
				@(posedge CLK_49M);
				r = $random(seed);
				cfg_waitrequest <= r[0];
			end
			// Quiet spell where any extra write would show up
			repeat (16) begin
				@(posedge CLK_49M);
				r = $random(seed);
				cfg_waitrequest <= r[0];
			end
		end
		cfg_waitrequest <= 1'b0;
	endtask

	initial begin
		seed = 32'h39c3;
		rst             <= 1'b1;
		ps2_key         <= '0;
		joystick_0      <= '0;
		joystick_1      <= '0;
		ioctl           <= '0;
		osd             <= '0;
		game_rgb        <= '0;
		cfg_waitrequest <= 1'b0;
		repeat (4) @(posedge CLK_49M);
		rst <= 1'b0;
		drive_key_events();
		mix_gamepads();
		load_dips();
		sweep_colours();
		sweep_aspect();
		cycle_underclock();
		repeat (4) @(posedge CLK_49M);
		if (exp_cfg.size() == 0 && i_jf_top.i_chk.failures == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			abort_run("Run ended with PLL writes outstanding or a failed assertion");
		end
	end

	// ============================================================
	// Timeout
	// ============================================================
	always @(posedge CLK_49M)
		cycle_count <= cycle_count + 1;

	initial begin
		wait (cycle_count >= MAX_CYCLES);
		abort_run($sformatf("Timeout: the run did not finish within %0d cycles", MAX_CYCLES));
	end

endmodule

`default_nettype wire

// ==== juno_first.f ====
+incdir+hw
hw/jf_pkg.sv
hw/jf_key_decoder.sv
hw/jf_cabinet_inputs.sv
hw/jf_pll_reconfig.sv
hw/jf_video_out.sv
hw/jf_top.sv
verif/jf_chk.sv
verif/jf_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the juno_first testbench with Verilator and runs it.
# Exit status is 0 only when the pass line is found in the output.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module jf_tb \
	--Mdir obj_dir -f juno_first.f; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vjf_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qxF "Simulation completed successfully"; then
	exit 0
fi
echo "Pass line not found in the simulator output"
exit 1
